// ==== verilog.f ====
+incdir+design
design/ex_pkg.sv
design/alu_if.sv
design/alu.sv
design/alu_encapsulator.sv
design/forwarding_unit.sv
design/pipeline_register.sv
design/ex_stage_top.sv
test/ex_stage_tb.sv

// ==== test/ex_stage_tb.sv ====
/* execute stage testbench */

`include "ex_defs.svh"

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int directed_max   = 64;   // upper bound on directed instructions.
    localparam int random_count   = 200;
    // each instruction is followed by at most one bubble.
    localparam int timeout_cycles = 2 * (directed_max + random_count) + 50;

    logic                      clk = 1'b0;
    logic                      reset = 1'b1;
    logic                      issue_valid = 1'b0;
    logic [`REG_ADDR_BITS-1:0] issue_rs1 = '0;
    logic [`REG_ADDR_BITS-1:0] issue_rs2 = '0;
    logic [`REG_ADDR_BITS-1:0] issue_rd = '0;
    logic [`XLEN-1:0]          issue_rs1_data = '0;
    logic [`XLEN-1:0]          issue_rs2_data = '0;
    logic [`XLEN-1:0]          issue_imm = '0;
    alu_op_e                   issue_alu_op = alu_add;
    logic                      issue_alu_src = 1'b0;
    logic                      issue_use_zero_a = 1'b0;
    logic                      issue_reg_write = 1'b0;
    logic                      wb_valid;
    logic [`REG_ADDR_BITS-1:0] wb_rd;
    logic                      wb_reg_write;
    logic [`XLEN-1:0]          wb_result;
    logic                      wb_zero;

    logic [`XLEN-1:0] regs [0:31];    // register file behind decode.
    logic [`XLEN-1:0] golden [0:31];  // program order view.
    int               cycle = 0;
    integer           seed = 32'he31;
    string            exp_name [$];
    ex_mem_t          exp_wb [$];
    int               exp_cycle [$];

    ex_stage_top i_ex_stage_top (.*);

    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("error: %s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input string field,
                                 input logic [`XLEN-1:0] expected,
                                 input logic [`XLEN-1:0] actual);
        $display("mismatch %s %s: expected %h actual %h", name, field, expected, actual);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic logic [`XLEN-1:0] alu_ref(input logic [3:0] op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            4'd0: return a + b;
            4'd1: return a + ~b + 1'b1;
            4'd2: return a & b;
            4'd3: return a | b;
            4'd4: return a ^ b;
            4'd5: return a << sh;
            4'd6: return a >> sh;
            4'd7: return (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
            4'd8: return ((a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : (a < b)) ? 1 : 0;
            4'd9: return (a < b) ? 1 : 0;
            default: return '0;
        endcase
    endfunction

    // write-first read with x0 tied to zero.
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_BITS-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb_valid && wb_reg_write && wb_rd == idx)
            return wb_result;  // written this cycle.
        return regs[idx];
    endfunction

    task automatic bubble();
        @(posedge clk);
        #2;
    endtask

    task automatic issue_instr(input string name, input logic [3:0] op,
                               input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [`XLEN-1:0] imm, input logic alu_src,
                               input logic use_zero_a, input logic reg_write);
        logic [`XLEN-1:0] result;
        ex_mem_t          entry;
        result = alu_ref(op, use_zero_a ? '0 : golden[rs1], alu_src ? imm : golden[rs2]);
        entry.rd        = rd;
        entry.reg_write = reg_write;
        entry.result    = result;
        entry.zero      = (result == '0);
        exp_name.push_back(name);
        exp_wb.push_back(entry);
        exp_cycle.push_back(cycle + 3);  // sampled next edge, visible two edges later.
        if (reg_write && rd != '0)
            golden[rd] = result;
        issue_valid      = 1'b1;
        issue_rs1        = rs1;
        issue_rs2        = rs2;
        issue_rd         = rd;
        issue_rs1_data   = read_reg(rs1);
        issue_rs2_data   = read_reg(rs2);
        issue_imm        = imm;
        issue_alu_op     = alu_op_e'(op);
        issue_alu_src    = alu_src;
        issue_use_zero_a = use_zero_a;
        issue_reg_write  = reg_write;
        bubble();
        issue_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == timeout_cycles)
            abort_run($sformatf("pipeline still busy after %0d cycles", cycle));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin : compare_wb
        string   name;
        ex_mem_t exp;
        int      due;
        if (!reset && wb_valid) begin
            assert (exp_wb.size() > 0) else abort_run("writeback with no instruction in flight");
            name = exp_name.pop_front();
            exp  = exp_wb.pop_front();
            due  = exp_cycle.pop_front();
            assert (cycle == due) else flag_mismatch(name, "cycle", due, cycle);
            assert (wb_rd == exp.rd) else flag_mismatch(name, "rd", exp.rd, wb_rd);
            assert (wb_reg_write == exp.reg_write)
                else flag_mismatch(name, "reg_write", exp.reg_write, wb_reg_write);
            assert (wb_result == exp.result)
                else flag_mismatch(name, "result", exp.result, wb_result);
            assert (wb_zero == exp.zero) else flag_mismatch(name, "zero", exp.zero, wb_zero);
            if (wb_reg_write && wb_rd != '0)
                regs[wb_rd] <= wb_result;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : stimulus
        int          i;
        logic [31:0] rnd;
        for (i = 0; i < 32; i++) begin
            regs[i]   = '0;
            golden[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) bubble();  // idle with no writeback expected.
        issue_instr("load_x1", 0, 1, 0, 0, 32'h8000_00f0, 1, 1, 1);
        issue_instr("load_x2", 0, 2, 0, 0, 32'h0000_0024, 1, 1, 1);
        repeat (3) bubble();  // loads retire before the op sweep.
        for (i = 0; i < 11; i++) begin
            issue_instr($sformatf("op%0d_x1_x2", i), i[3:0], 10 + i, 1, 2, '0, 0, 0, 1);
            bubble();
        end
        for (i = 0; i < 10; i++) begin
            issue_instr($sformatf("op%0d_x2_x1", i), i[3:0], 21 + i, 2, 1, '0, 0, 0, 1);
            bubble();
        end
        issue_instr("sub_zero", 1, 31, 1, 1, '0, 0, 0, 1);
        issue_instr("fwd_ex_mem", 0, 4, 1, 2, '0, 0, 0, 1);
        issue_instr("fwd_ex_mem_dep", 0, 5, 4, 4, '0, 0, 0, 1);
        issue_instr("fwd_both_stages", 1, 6, 5, 4, '0, 0, 0, 1);
        issue_instr("older_x7", 0, 7, 0, 0, 32'd5, 1, 1, 1);
        issue_instr("newer_x7", 0, 7, 0, 0, 32'd9, 1, 1, 1);
        issue_instr("newest_wins", 0, 8, 7, 0, '0, 0, 0, 1);
        issue_instr("x7_mem_wb", 4, 3, 7, 8, '0, 0, 0, 1);
        issue_instr("x7_regfile", 3, 3, 7, 3, '0, 0, 0, 1);
        issue_instr("load_x9", 0, 9, 0, 0, 32'h1234, 1, 1, 1);
        repeat (3) bubble();
        issue_instr("write_x0", 0, 0, 1, 2, '0, 0, 0, 1);
        issue_instr("x0_no_fwd", 0, 10, 0, 9, '0, 0, 0, 1);
        issue_instr("no_write_x9", 4, 9, 1, 2, '0, 0, 0, 0);
        issue_instr("reg_write_low", 0, 11, 9, 0, '0, 0, 0, 1);
        issue_instr("prod_x12", 0, 12, 1, 2, '0, 0, 0, 1);
        issue_instr("imm_over_fwd", 0, 13, 12, 12, 32'h100, 1, 0, 1);
        issue_instr("zero_a_over_fwd", 0, 14, 12, 12, 32'h55, 1, 1, 1);
        issue_instr("zero_a_reg_b", 3, 15, 12, 12, '0, 0, 1, 1);
        for (i = 0; i < random_count; i++) begin
            rnd = $random(seed);
            issue_instr($sformatf("random_%0d", i), rnd[7:0] % 10, rnd[10:8], rnd[13:11],
                        rnd[16:14], $random(seed), rnd[18:17] == 2'd0, rnd[21:19] == 3'd0,
                        rnd[24:22] != 3'd0);
            if (rnd[26:25] == 2'd0)
                bubble();
        end
        repeat (6) bubble();  // drain.
        if (exp_wb.size() != 0) begin
            abort_run($sformatf("%0d instructions never wrote back", exp_wb.size()));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== design/ex_stage_top.sv ====
/* execute stage pipeline */

`include "ex_defs.svh"

module ex_stage_top
    import ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      issue_valid,
    input  logic [`REG_ADDR_BITS-1:0] issue_rs1,
    input  logic [`REG_ADDR_BITS-1:0] issue_rs2,
    input  logic [`REG_ADDR_BITS-1:0] issue_rd,
    input  logic [`XLEN-1:0]          issue_rs1_data,
    input  logic [`XLEN-1:0]          issue_rs2_data,
    input  logic [`XLEN-1:0]          issue_imm,
    input  alu_op_e                   issue_alu_op,
    input  logic                      issue_alu_src,
    input  logic                      issue_use_zero_a,
    input  logic                      issue_reg_write,

    output logic                      wb_valid,
    output logic [`REG_ADDR_BITS-1:0] wb_rd,
    output logic                      wb_reg_write,
    output logic [`XLEN-1:0]          wb_result,
    output logic                      wb_zero
);

    id_ex_t  id_ex_in;
    id_ex_t  id_ex;
    logic    id_ex_valid;
    ex_mem_t ex_mem_in;
    ex_mem_t ex_mem;
    logic    ex_mem_valid;
    ex_mem_t mem_wb;
    logic    mem_wb_valid;

    alu_if   alu_bus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ID/EX
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign id_ex_in = '{
        rs1:        issue_rs1,
        rs2:        issue_rs2,
        rd:         issue_rd,
        rs1_data:   issue_rs1_data,
        rs2_data:   issue_rs2_data,
        imm:        issue_imm,
        alu_op:     issue_alu_op,
        alu_src:    issue_alu_src,
        use_zero_a: issue_use_zero_a,
        reg_write:  issue_reg_write
    };

    pipeline_register #(.payload_t(id_ex_t)) i_id_ex (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (issue_valid),
        .in_data   (id_ex_in),
        .out_valid (id_ex_valid),
        .out_data  (id_ex)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign alu_bus.reg_data_a    = id_ex.rs1_data;
    assign alu_bus.reg_data_b    = id_ex.rs2_data;
    assign alu_bus.imm           = id_ex.imm;
    assign alu_bus.alu_op        = id_ex.alu_op;
    assign alu_bus.ex_mem_result = ex_mem.result;   // forwarding sources.
    assign alu_bus.mem_wb_result = mem_wb.result;

    forwarding_unit i_forwarding_unit (
        .id_ex        (id_ex),
        .ex_mem_valid (ex_mem_valid),
        .ex_mem       (ex_mem),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb),
        .fwd_bus      (alu_bus)
    );

    alu_encapsulator i_alu_encapsulator (
        .alu_bus (alu_bus)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX/MEM and MEM/WB
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ex_mem_in = '{
        rd:        id_ex.rd,
        reg_write: id_ex_valid && id_ex.reg_write,  // bubbles never write.
        result:    alu_bus.result,
        zero:      alu_bus.zero
    };

    pipeline_register #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (id_ex_valid),
        .in_data   (ex_mem_in),
        .out_valid (ex_mem_valid),
        .out_data  (ex_mem)
    );

    pipeline_register #(.payload_t(ex_mem_t)) i_mem_wb (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ex_mem_valid),
        .in_data   (ex_mem),
        .out_valid (mem_wb_valid),
        .out_data  (mem_wb)
    );

    assign wb_valid     = mem_wb_valid;
    assign wb_rd        = mem_wb.rd;
    assign wb_reg_write = mem_wb_valid && mem_wb.reg_write;
    assign wb_result    = mem_wb.result;
    assign wb_zero      = mem_wb.zero;

endmodule

// ==== design/pipeline_register.sv ====
/* pipeline stage register */

module pipeline_register #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // control bit.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload loads every cycle, qualified by out_valid.
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

// ==== design/forwarding_unit.sv ====
/* operand forwarding control */

`include "ex_defs.svh"

module forwarding_unit
    import ex_pkg::*;
(
    input  id_ex_t    id_ex,
    input  logic      ex_mem_valid,
    input  ex_mem_t   ex_mem,
    input  logic      mem_wb_valid,
    input  ex_mem_t   mem_wb,
    alu_if.fwd        fwd_bus
);

    // stage holds a pending write to rs.
    function automatic logic writes_reg(
        input logic                      valid,
        input ex_mem_t                   stage,
        input logic [`REG_ADDR_BITS-1:0] rs
    );
        return valid && stage.reg_write && (stage.rd != '0) && (stage.rd == rs);
    endfunction

    function automatic fwd_sel_e pick_source(
        input logic                      use_alt,
        input logic [`REG_ADDR_BITS-1:0] rs,
        input logic                      ex_mem_hit_valid,
        input ex_mem_t                   ex_mem_stage,
        input logic                      mem_wb_hit_valid,
        input ex_mem_t                   mem_wb_stage
    );
        fwd_sel_e sel;
        if (use_alt)
            sel = fwd_alt;
        else if (writes_reg(ex_mem_hit_valid, ex_mem_stage, rs))
            sel = fwd_ex_mem;  // newest result wins.
        else if (writes_reg(mem_wb_hit_valid, mem_wb_stage, rs))
            sel = fwd_mem_wb;
        else
            sel = fwd_reg;
        return sel;
    endfunction

    always_comb begin
        fwd_bus.fwd_a = pick_source(id_ex.use_zero_a, id_ex.rs1,
                                    ex_mem_valid, ex_mem, mem_wb_valid, mem_wb);
        fwd_bus.fwd_b = pick_source(id_ex.alu_src, id_ex.rs2,
                                    ex_mem_valid, ex_mem, mem_wb_valid, mem_wb);
    end

endmodule

// ==== design/alu_encapsulator.sv ====
/* alu with operand selection */

`include "ex_defs.svh"

module alu_encapsulator
    import ex_pkg::*;
(
    alu_if.ex alu_bus
);

    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand muxes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (alu_bus.fwd_a)
            fwd_reg:    operand_a = alu_bus.reg_data_a;
            fwd_ex_mem: operand_a = alu_bus.ex_mem_result;
            fwd_mem_wb: operand_a = alu_bus.mem_wb_result;
            default:    operand_a = '0;  // use_zero_a path.
        endcase
    end

    always_comb begin
        case (alu_bus.fwd_b)
            fwd_reg:    operand_b = alu_bus.reg_data_b;
            fwd_ex_mem: operand_b = alu_bus.ex_mem_result;
            fwd_mem_wb: operand_b = alu_bus.mem_wb_result;
            default:    operand_b = alu_bus.imm;
        endcase
    end

    alu i_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .operation (alu_bus.alu_op),
        .result    (alu_bus.result),
        .zero      (alu_bus.zero)
    );

endmodule

// ==== design/alu.sv ====
/* integer alu */

`include "ex_defs.svh"

module alu
    import ex_pkg::*;
(
    input  logic [`XLEN-1:0] operand_a,
    input  logic [`XLEN-1:0] operand_b,
    input  alu_op_e          operation,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];  // rv32 shift amount.

    always_comb begin
        case (operation)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            alu_and:  result = operand_a & operand_b;
            alu_or:   result = operand_a | operand_b;
            alu_xor:  result = operand_a ^ operand_b;
            alu_sll:  result = operand_a << shamt;
            alu_srl:  result = operand_a >> shamt;
            alu_sra:  result = $signed(operand_a) >>> shamt;
            alu_slt: begin
                result = '0;
                result[0] = $signed(operand_a) < $signed(operand_b);
            end
            alu_sltu: begin
                result = '0;
                result[0] = operand_a < operand_b;
            end
            default:  result = '0;  // unused codes.
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== design/alu_if.sv ====
/* alu operand and result bundle */

`include "ex_defs.svh"

interface alu_if import ex_pkg::*; ();

    logic [`XLEN-1:0] reg_data_a;
    logic [`XLEN-1:0] reg_data_b;
    logic [`XLEN-1:0] imm;

    fwd_sel_e         fwd_a;
    fwd_sel_e         fwd_b;

    logic [`XLEN-1:0] ex_mem_result;   // one instruction older.
    logic [`XLEN-1:0] mem_wb_result;   // two instructions older.

    alu_op_e          alu_op;

    logic [`XLEN-1:0] result;
    logic             zero;

    modport top (
        output reg_data_a, reg_data_b, imm, ex_mem_result, mem_wb_result, alu_op,
        input  result, zero
    );

    modport fwd (
        output fwd_a, fwd_b
    );

    modport ex (
        input  reg_data_a, reg_data_b, imm, fwd_a, fwd_b,
        input  ex_mem_result, mem_wb_result, alu_op,
        output result, zero
    );

endinterface

// ==== design/ex_pkg.sv ====
/* execute stage types */

`include "ex_defs.svh"

package ex_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu and forwarding encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,   // signed.
        alu_sltu = 4'd9    // unsigned.
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_reg    = 2'd0,
        fwd_ex_mem = 2'd1,
        fwd_mem_wb = 2'd2,
        fwd_alt    = 2'd3  // zero on a, immediate on b.
    } fwd_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [`REG_ADDR_BITS-1:0] rs1;
        logic [`REG_ADDR_BITS-1:0] rs2;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`XLEN-1:0]          rs1_data;
        logic [`XLEN-1:0]          rs2_data;
        logic [`XLEN-1:0]          imm;
        alu_op_e                   alu_op;
        logic                      alu_src;     // b from immediate.
        logic                      use_zero_a;  // a forced to zero.
        logic                      reg_write;
    } id_ex_t;

    // shared by EX/MEM and MEM/WB.
    typedef struct packed {
        logic [`REG_ADDR_BITS-1:0] rd;
        logic                      reg_write;
        logic [`XLEN-1:0]          result;
        logic                      zero;
    } ex_mem_t;

endpackage

// ==== design/ex_defs.svh ====
/* execute stage widths */

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define XLEN            32  // integer register width.
`define REG_ADDR_BITS   5   // x0 to x31.

`endif
